// ==== rtl/core_cfg.svh ====
`ifndef CORE_CFG_SVH
`define CORE_CFG_SVH

// Datapath and register file geometry
`define CORE_XLEN       32
`define CORE_NREGS      16
`define CORE_RADDR_W    4

// Program counter behaviour
`define CORE_PC_STEP    32'd4
`define CORE_RESET_PC   32'h0000_0000

// Opcodes kept from the RISC-V style encoding
`define CORE_OP_R       7'b0110011
`define CORE_OP_I       7'b0010011
`define CORE_OP_LOAD    7'b0000011
`define CORE_OP_STORE   7'b0100011
`define CORE_OP_LUI     7'b0110111

`endif

// ==== rtl/core_pkg.sv ====
`default_nettype none
`include "core_cfg.svh"

package core_pkg;

    typedef struct packed {
        logic [6:0]               funct7;
        logic [`CORE_RADDR_W-1:0] rs2;
        logic                     spare_20;
        logic [`CORE_RADDR_W-1:0] rs1;
        logic                     spare_15;
        logic [2:0]               funct3;
        logic [`CORE_RADDR_W-1:0] rd;
        logic                     spare_7;
        logic [6:0]               opcode;
    } instr_reg_t;

    typedef struct packed {
        logic [11:0] imm_hi;    // I immediate, upper part of S
        logic [7:0]  imm_mid;   // Completes U immediate
        logic [4:0]  imm_lo;    // Lower part of S
        logic [6:0]  opcode;
    } instr_imm_t;

    // Same word, read as register fields or as immediate fields
    typedef union packed {
        instr_reg_t r;
        instr_imm_t i;
    } instr_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B
    } alu_op_e;

    typedef struct packed {
        logic [`CORE_XLEN-1:0]    rs1_val;
        logic [`CORE_XLEN-1:0]    rs2_val;
        logic [`CORE_XLEN-1:0]    imm;
        logic [`CORE_RADDR_W-1:0] rs1;
        logic [`CORE_RADDR_W-1:0] rs2;
        logic [`CORE_RADDR_W-1:0] rd;
        alu_op_e                  alu_op;
        logic                     alu_src;   // Operand B from immediate
        logic                     reg_write;
        logic                     mem_read;
        logic                     mem_write;
    } id_ex_t;

    typedef struct packed {
        logic [`CORE_XLEN-1:0]    alu_res;
        logic [`CORE_XLEN-1:0]    store_data;
        logic [`CORE_RADDR_W-1:0] rd;
        logic                     reg_write;
        logic                     mem_read;
        logic                     mem_write;
    } ex_mem_t;

    typedef struct packed {
        logic                     we;
        logic [`CORE_RADDR_W-1:0] rd;
        logic [`CORE_XLEN-1:0]    data;
    } wb_t;

endpackage

`default_nettype wire

// ==== rtl/core_fetch.sv ====
`default_nettype none
`timescale 1ns/1ps
`include "core_cfg.svh"

module core_fetch
    import core_pkg::*;
(
    input  logic                  CLK,
    input  logic                  RESET_N,
    input  logic                  stall,
    input  logic [`CORE_XLEN-1:0] INSTR,
    output logic [`CORE_XLEN-1:0] pc,
    output instr_t                if_instr,
    output logic                  if_valid
);

    always_ff @(posedge CLK or negedge RESET_N) begin
        if (!RESET_N) begin
            pc       <= `CORE_RESET_PC;
            if_valid <= 1'b0;
        end else if (!stall) begin
            pc       <= pc + `CORE_PC_STEP;
            if_valid <= 1'b1;               // First fetched word arrives
        end
    end

    // Instruction held in place while decode waits on a load
    always_ff @(posedge CLK) begin
        if (!stall) begin
            if_instr <= INSTR;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/reg_file.sv ====
`default_nettype none
`timescale 1ns/1ps
`include "core_cfg.svh"

module reg_file
    import core_pkg::*;
(
    input  logic                     CLK,
    input  logic                     RESET_N,
    input  logic [`CORE_RADDR_W-1:0] rs1_idx,
    input  logic [`CORE_RADDR_W-1:0] rs2_idx,
    output logic [`CORE_XLEN-1:0]    rs1_val,
    output logic [`CORE_XLEN-1:0]    rs2_val,
    input  wb_t                      wb
);

    logic [`CORE_XLEN-1:0] regs [`CORE_NREGS];

    always_ff @(posedge CLK or negedge RESET_N) begin
        if (!RESET_N) begin
            regs <= '{default: '0};
        end else if (wb.we && (wb.rd != '0)) begin
            regs[wb.rd] <= wb.data;
        end
    end

    // r0 is hardwired, otherwise a same-cycle write passes through
    assign rs1_val = (rs1_idx == '0) ? '0 :
                     (wb.we && (wb.rd == rs1_idx)) ? wb.data : regs[rs1_idx];
    assign rs2_val = (rs2_idx == '0) ? '0 :
                     (wb.we && (wb.rd == rs2_idx)) ? wb.data : regs[rs2_idx];

endmodule

`default_nettype wire

// ==== rtl/core_decode.sv ====
`default_nettype none
`timescale 1ns/1ps
`include "core_cfg.svh"

module core_decode
    import core_pkg::*;
(
    input  logic   CLK,
    input  logic   RESET_N,
    input  instr_t if_instr,
    input  logic   if_valid,
    input  wb_t    wb,
    output logic   stall,
    output id_ex_t id_ex
);

    logic [`CORE_XLEN-1:0] rs1_val;
    logic [`CORE_XLEN-1:0] rs2_val;
    logic [`CORE_XLEN-1:0] imm_i;
    logic [`CORE_XLEN-1:0] imm_s;
    logic [`CORE_XLEN-1:0] imm_u;
    id_ex_t                id_ex_d;

    // SUB exists only in the register group, SRA in both
    function automatic alu_op_e alu_op_decode(input logic [2:0] funct3,
                                              input logic       alt,
                                              input logic       reg_op);
        alu_op_e op;
        case (funct3)
            3'b000:  op = (alt && reg_op) ? ALU_SUB : ALU_ADD;
            3'b001:  op = ALU_SLL;
            3'b010:  op = ALU_SLT;
            3'b011:  op = ALU_SLTU;
            3'b100:  op = ALU_XOR;
            3'b101:  op = alt ? ALU_SRA : ALU_SRL;
            3'b110:  op = ALU_OR;
            default: op = ALU_AND;
        endcase
        return op;
    endfunction

    reg_file reg_file_i (
        .CLK     (CLK),
        .RESET_N (RESET_N),
        .rs1_idx (if_instr.r.rs1),
        .rs2_idx (if_instr.r.rs2),
        .rs1_val (rs1_val),
        .rs2_val (rs2_val),
        .wb      (wb)
    );

    assign imm_i = {{(`CORE_XLEN-12){if_instr.i.imm_hi[11]}}, if_instr.i.imm_hi};
    assign imm_s = {{(`CORE_XLEN-12){if_instr.i.imm_hi[11]}}, if_instr.i.imm_hi[11:5],
                    if_instr.i.imm_lo};
    assign imm_u = {if_instr.i.imm_hi, if_instr.i.imm_mid, 12'b0};

    always_comb begin
        id_ex_d         = '0;                // Unknown opcode stays a bubble
        id_ex_d.rs1_val = rs1_val;
        id_ex_d.rs2_val = rs2_val;
        id_ex_d.rs1     = if_instr.r.rs1;
        id_ex_d.rs2     = if_instr.r.rs2;
        id_ex_d.rd      = if_instr.r.rd;
        if (if_valid) begin
            case (if_instr.r.opcode)
                `CORE_OP_R: begin
                    id_ex_d.reg_write = 1'b1;
                    id_ex_d.alu_op    = alu_op_decode(if_instr.r.funct3,
                                                      if_instr.r.funct7[5], 1'b1);
                end
                `CORE_OP_I: begin
                    id_ex_d.reg_write = 1'b1;
                    id_ex_d.alu_src   = 1'b1;
                    id_ex_d.imm       = imm_i;
                    id_ex_d.alu_op    = alu_op_decode(if_instr.r.funct3,
                                                      if_instr.r.funct7[5], 1'b0);
                end
                `CORE_OP_LOAD: begin
                    id_ex_d.reg_write = 1'b1;
                    id_ex_d.mem_read  = 1'b1;
                    id_ex_d.alu_src   = 1'b1;
                    id_ex_d.imm       = imm_i;       // Address is rs1 + offset
                end
                `CORE_OP_STORE: begin
                    id_ex_d.mem_write = 1'b1;
                    id_ex_d.alu_src   = 1'b1;
                    id_ex_d.imm       = imm_s;
                end
                `CORE_OP_LUI: begin
                    id_ex_d.reg_write = 1'b1;
                    id_ex_d.alu_src   = 1'b1;
                    id_ex_d.imm       = imm_u;
                    id_ex_d.alu_op    = ALU_PASS_B;
                end
                default: ;
            endcase
        end
    end

    // Load in execute feeding the instruction in decode
    assign stall = id_ex.mem_read && (id_ex.rd != '0) &&
                   ((id_ex.rd == if_instr.r.rs1) || (id_ex.rd == if_instr.r.rs2));

    always_ff @(posedge CLK or negedge RESET_N) begin
        if (!RESET_N) begin
            id_ex <= '0;
        end else if (stall) begin
            id_ex <= '0;                     // Bubble
        end else begin
            id_ex <= id_ex_d;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/core_execute.sv ====
`default_nettype none
`timescale 1ns/1ps
`include "core_cfg.svh"

module core_execute
    import core_pkg::*;
(
    input  logic    CLK,
    input  logic    RESET_N,
    input  id_ex_t  id_ex,
    input  wb_t     wb,
    output ex_mem_t ex_mem
);

    logic [`CORE_XLEN-1:0] op_a;
    logic [`CORE_XLEN-1:0] fwd_b;
    logic [`CORE_XLEN-1:0] op_b;
    logic [4:0]            shamt;
    logic [`CORE_XLEN-1:0] alu_res;

    // Memory stage wins over writeback; a load result is not ready there yet
    function automatic logic [`CORE_XLEN-1:0] fwd_sel(input logic [`CORE_RADDR_W-1:0] src,
                                                      input logic [`CORE_XLEN-1:0]    reg_val,
                                                      input ex_mem_t                  mem_s,
                                                      input wb_t                      wb_s);
        logic [`CORE_XLEN-1:0] val;
        if (mem_s.reg_write && !mem_s.mem_read && (mem_s.rd != '0) && (mem_s.rd == src)) begin
            val = mem_s.alu_res;
        end else if (wb_s.we && (wb_s.rd != '0) && (wb_s.rd == src)) begin
            val = wb_s.data;
        end else begin
            val = reg_val;
        end
        return val;
    endfunction

    assign op_a  = fwd_sel(id_ex.rs1, id_ex.rs1_val, ex_mem, wb);
    assign fwd_b = fwd_sel(id_ex.rs2, id_ex.rs2_val, ex_mem, wb);
    assign op_b  = id_ex.alu_src ? id_ex.imm : fwd_b;
    assign shamt = op_b[4:0];

    always_comb begin
        case (id_ex.alu_op)
            ALU_ADD:    alu_res = op_a + op_b;
            ALU_SUB:    alu_res = op_a - op_b;
            ALU_SLL:    alu_res = op_a << shamt;
            ALU_SLT:    alu_res = {31'b0, $signed(op_a) < $signed(op_b)};
            ALU_SLTU:   alu_res = {31'b0, op_a < op_b};
            ALU_XOR:    alu_res = op_a ^ op_b;
            ALU_SRL:    alu_res = op_a >> shamt;
            ALU_SRA:    alu_res = $signed(op_a) >>> shamt;
            ALU_OR:     alu_res = op_a | op_b;
            ALU_AND:    alu_res = op_a & op_b;
            ALU_PASS_B: alu_res = op_b;      // LUI
            default:    alu_res = '0;
        endcase
    end

    always_ff @(posedge CLK or negedge RESET_N) begin
        if (!RESET_N) begin
            ex_mem <= '0;
        end else begin
            ex_mem.alu_res    <= alu_res;
            ex_mem.store_data <= fwd_b;      // Forwarded even when B is the immediate
            ex_mem.rd         <= id_ex.rd;
            ex_mem.reg_write  <= id_ex.reg_write;
            ex_mem.mem_read   <= id_ex.mem_read;
            ex_mem.mem_write  <= id_ex.mem_write;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/core_mem_wb.sv ====
`default_nettype none
`timescale 1ns/1ps
`include "core_cfg.svh"

module core_mem_wb
    import core_pkg::*;
(
    input  logic                  CLK,
    input  logic                  RESET_N,
    input  ex_mem_t               ex_mem,
    input  logic [`CORE_XLEN-1:0] DIN,
    output logic                  DREQ,
    output logic                  DRW,
    output logic [`CORE_XLEN-1:0] DADDR,
    output logic [`CORE_XLEN-1:0] DOUT,
    output wb_t                   wb
);

    logic                     wb_we;
    logic                     wb_load;
    logic [`CORE_RADDR_W-1:0] wb_rd;
    logic [`CORE_XLEN-1:0]    wb_alu;
    logic [`CORE_XLEN-1:0]    wb_din;

    assign DREQ  = ex_mem.mem_read | ex_mem.mem_write;
    assign DRW   = ex_mem.mem_write;
    assign DADDR = ex_mem.alu_res;
    assign DOUT  = ex_mem.store_data;

    always_ff @(posedge CLK or negedge RESET_N) begin
        if (!RESET_N) begin
            wb_we   <= 1'b0;
            wb_load <= 1'b0;
        end else begin
            wb_we   <= ex_mem.reg_write;
            wb_load <= ex_mem.mem_read;
        end
    end

    always_ff @(posedge CLK) begin
        wb_rd  <= ex_mem.rd;
        wb_alu <= ex_mem.alu_res;
        wb_din <= DIN;                       // Same-cycle read data
    end

    always_comb begin
        wb.we   = wb_we;
        wb.rd   = wb_rd;
        wb.data = wb_load ? wb_din : wb_alu;
    end

endmodule

`default_nettype wire

// ==== rtl/core_top.sv ====
`default_nettype none
`timescale 1ns/1ps
`include "core_cfg.svh"

module core_top
    import core_pkg::*;
(
    input  logic                  CLK,
    input  logic                  RESET_N,
    output logic                  IREQ,
    output logic [`CORE_XLEN-1:0] IADDR,
    input  logic [`CORE_XLEN-1:0] INSTR,
    output logic                  DREQ,
    output logic [`CORE_XLEN-1:0] DADDR,
    output logic                  DRW,
    input  logic [`CORE_XLEN-1:0] DIN,
    output logic [`CORE_XLEN-1:0] DOUT
);

    logic    stall;
    instr_t  if_instr;
    logic    if_valid;
    id_ex_t  id_ex;
    ex_mem_t ex_mem;
    wb_t     wb;

    assign IREQ = RESET_N;                   // Fetch runs whenever out of reset

    core_fetch core_fetch_i (
        .CLK      (CLK),
        .RESET_N  (RESET_N),
        .stall    (stall),
        .INSTR    (INSTR),
        .pc       (IADDR),
        .if_instr (if_instr),
        .if_valid (if_valid)
    );

    core_decode core_decode_i (
        .CLK      (CLK),
        .RESET_N  (RESET_N),
        .if_instr (if_instr),
        .if_valid (if_valid),
        .wb       (wb),
        .stall    (stall),
        .id_ex    (id_ex)
    );

    core_execute core_execute_i (
        .CLK     (CLK),
        .RESET_N (RESET_N),
        .id_ex   (id_ex),
        .wb      (wb),
        .ex_mem  (ex_mem)
    );

    core_mem_wb core_mem_wb_i (
        .CLK     (CLK),
        .RESET_N (RESET_N),
        .ex_mem  (ex_mem),
        .DIN     (DIN),
        .DREQ    (DREQ),
        .DRW     (DRW),
        .DADDR   (DADDR),
        .DOUT    (DOUT),
        .wb      (wb)
    );

endmodule

`default_nettype wire

// ==== test/tb_core.sv ====
`default_nettype none
`timescale 1ns/1ps
`include "core_cfg.svh"

module tb_core;

    logic        CLK;
    logic        RESET_N;
    logic        IREQ;
    logic [31:0] IADDR;
    logic [31:0] INSTR;
    logic        DREQ;
    logic [31:0] DADDR;
    logic        DRW;
    logic [31:0] DIN;
    logic [31:0] DOUT;

    logic [31:0] imem [64];
    logic [31:0] dmem [64];
    logic [31:0] exp_addr [$];
    logic [31:0] exp_data [$];
    string       tags [$];
    int          prog_len;
    int          limit;
    integer      seed;
    logic        prog_ready = 1'b0;

    core_top core_top_i (
        .CLK     (CLK),
        .RESET_N (RESET_N),
        .IREQ    (IREQ),
        .IADDR   (IADDR),
        .INSTR   (INSTR),
        .DREQ    (DREQ),
        .DADDR   (DADDR),
        .DRW     (DRW),
        .DIN     (DIN),
        .DOUT    (DOUT)
    );

    assign INSTR = (IADDR < 32'd256) ? imem[IADDR[7:2]] : '0;  // Zero past the array
    assign DIN   = dmem[DADDR[7:2]];

    always @(posedge CLK) begin
        if (DREQ && DRW) begin
            dmem[DADDR[7:2]] <= DOUT;
        end
    end

    initial begin
        CLK = 1'b0;
        forever #5 CLK = ~CLK;
    end

    function automatic logic [31:0] r_word(input logic [6:0] f7, input logic [3:0] rs2,
                                           input logic [3:0] rs1, input logic [2:0] f3,
                                           input logic [3:0] rd);
        return {f7, rs2, 1'b0, rs1, 1'b0, f3, rd, 1'b0, `CORE_OP_R};
    endfunction

    function automatic logic [31:0] i_word(input logic [11:0] imm, input logic [3:0] rs1,
                                           input logic [2:0] f3, input logic [3:0] rd,
                                           input logic [6:0] op);
        return {imm, rs1, 1'b0, f3, rd, 1'b0, op};
    endfunction

    function automatic logic [31:0] s_word(input logic [11:0] imm, input logic [3:0] rs2,
                                           input logic [3:0] rs1);
        return {imm[11:5], rs2, 1'b0, rs1, 1'b0, 3'b010, imm[4:0], `CORE_OP_STORE};
    endfunction

    function automatic logic [31:0] u_word(input logic [19:0] imm, input logic [3:0] rd);
        return {imm, rd, 1'b0, `CORE_OP_LUI};
    endfunction

    task automatic emit_word(input logic [31:0] w);
        imem[prog_len] = w;
        prog_len++;
    endtask

    task automatic store_reg(input string name, input logic [11:0] addr,
                             input logic [3:0] rs2);
        emit_word(s_word(addr, rs2, 4'd0));        // Base is r0
        tags.push_back(name);
    endtask

    // Result always lands in r6 and goes straight to memory
    task automatic run_and_store(input string name, input logic [31:0] w,
                                 input logic [11:0] addr);
        emit_word(w);
        store_reg(name, addr, 4'd6);
    endtask

    task automatic pad_independent(input int n);
        repeat (n) emit_word(i_word(12'h055, 4'd0, 3'b000, 4'd12, `CORE_OP_I));
    endtask

    function automatic logic [31:0] alu_model(input logic [2:0] f3, input logic alt,
                                              input logic is_reg, input logic [31:0] a,
                                              input logic [31:0] b);
        logic [31:0] r;
        case (f3)
            3'b000:  r = (alt && is_reg) ? a - b : a + b;
            3'b001:  r = a << b[4:0];
            3'b010:  r = {31'b0, $signed(a) < $signed(b)};
            3'b011:  r = {31'b0, a < b};
            3'b100:  r = a ^ b;
            3'b110:  r = a | b;
            3'b111:  r = a & b;
            default: r = a >> b[4:0];
        endcase
        if (f3 == 3'b101 && alt) begin
            r = $signed(a) >>> b[4:0];
        end
        return r;
    endfunction

    // In-order model of the program, fills the expected store list
    function automatic void predict_stores();
        logic [31:0] regs [16];
        logic [31:0] mem [64];
        logic [31:0] w;
        logic [31:0] res;
        logic [31:0] addr;
        logic [31:0] imm_i;
        logic        wr;
        for (int k = 0; k < 16; k++) regs[k] = '0;
        for (int k = 0; k < 64; k++) mem[k] = 32'hD0D0_0000 | k;
        for (int pc = 0; pc < prog_len; pc++) begin
            w     = imem[pc];
            imm_i = {{20{w[31]}}, w[31:20]};
            wr    = 1'b1;
            res   = '0;
            case (w[6:0])
                `CORE_OP_R:    res = alu_model(w[14:12], w[30], 1'b1, regs[w[19:16]],
                                               regs[w[24:21]]);
                `CORE_OP_I:    res = alu_model(w[14:12], w[30], 1'b0, regs[w[19:16]], imm_i);
                `CORE_OP_LUI:  res = {w[31:12], 12'b0};
                `CORE_OP_LOAD: begin
                    addr = regs[w[19:16]] + imm_i;
                    res  = mem[addr[7:2]];
                end
                `CORE_OP_STORE: begin
                    addr = regs[w[19:16]] + {{20{w[31]}}, w[31:25], w[11:7]};
                    mem[addr[7:2]] = regs[w[24:21]];
                    exp_addr.push_back(addr);
                    exp_data.push_back(regs[w[24:21]]);
                    wr = 1'b0;
                end
                default: wr = 1'b0;
            endcase
            if (wr && w[11:8] != 4'd0) regs[w[11:8]] = res;
        end
    endfunction

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("Simulation finished: FAIL");
        $fatal(1, "Run stopped on error");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            stop_with_failure($sformatf("** Error: %s expected %h actual %h",
                                        name, expected, actual));
        end
    endtask

    initial begin : stimulus
        logic [31:0] v1;
        logic [31:0] v2;
        RESET_N  = 1'b0;
        seed     = 52;
        prog_len = 0;
        for (int k = 0; k < 64; k++) begin
            imem[k] = '0;
            dmem[k] = 32'hD0D0_0000 | k;
        end
        v1 = $random(seed);
        v2 = $random(seed);
        emit_word(u_word(v1[31:12] + {19'b0, v1[11]}, 4'd1));
        emit_word(i_word(v1[11:0], 4'd1, 3'b000, 4'd1, `CORE_OP_I));
        emit_word(u_word(v2[31:12] + {19'b0, v2[11]}, 4'd2));
        emit_word(i_word(v2[11:0], 4'd2, 3'b000, 4'd2, `CORE_OP_I));
        v1 = $random(seed);
        emit_word(u_word({1'b1, v1[18:0]}, 4'd3));       // Negative operand
        for (int k = 0; k < 10; k++) begin
            run_and_store("rr_ops", r_word((k < 8) ? 7'h00 : 7'h20, 4'd2, 4'd1,
                          (k < 8) ? k[2:0] : ((k == 8) ? 3'b000 : 3'b101), 4'd6),
                          12'(4 * k));
        end
        v1 = $random(seed);
        run_and_store("imm_ops", i_word(12'hF9C, 4'd1, 3'b000, 4'd6, `CORE_OP_I), 12'd64);
        run_and_store("imm_ops", i_word(v1[11:0], 4'd3, 3'b010, 4'd6, `CORE_OP_I), 12'd68);
        run_and_store("imm_ops", i_word(v1[23:12], 4'd3, 3'b011, 4'd6, `CORE_OP_I), 12'd72);
        run_and_store("imm_ops", i_word(12'hF0F, 4'd2, 3'b100, 4'd6, `CORE_OP_I), 12'd76);
        run_and_store("imm_ops", i_word(v1[31:20], 4'd1, 3'b111, 4'd6, `CORE_OP_I), 12'd80);
        run_and_store("imm_ops", i_word(12'h025, 4'd1, 3'b001, 4'd6, `CORE_OP_I), 12'd84);
        run_and_store("imm_ops", i_word(12'h009, 4'd3, 3'b101, 4'd6, `CORE_OP_I), 12'd88);
        run_and_store("imm_ops", i_word(12'h409, 4'd3, 3'b101, 4'd6, `CORE_OP_I), 12'd92);
        store_reg("lui", 12'd96, 4'd3);
        for (int d = 1; d <= 3; d++) begin
            emit_word(i_word(12'(d * 7), 4'd1, 3'b000, 4'd10, `CORE_OP_I));
            pad_independent(d - 1);
            emit_word(r_word(7'h00, 4'd2, 4'd10, 3'b000, 4'd13));  // Operand A consumer
            pad_independent(d - 1);
            store_reg("forwarding", 12'(124 + 4 * d), 4'd13);       // Store data consumer
        end
        emit_word(i_word(12'd0, 4'd0, 3'b010, 4'd14, `CORE_OP_LOAD));
        emit_word(i_word(12'd3, 4'd14, 3'b000, 4'd15, `CORE_OP_I));  // Load-use stall
        store_reg("loads", 12'd192, 4'd15);
        emit_word(i_word(12'd4, 4'd0, 3'b010, 4'd14, `CORE_OP_LOAD));
        store_reg("loads", 12'd196, 4'd14);
        emit_word(i_word(12'd5, 4'd1, 3'b000, 4'd0, `CORE_OP_I));   // Write to r0
        store_reg("r0_write", 12'd200, 4'd0);
        predict_stores();
        limit      = 2 * prog_len + 20;
        prog_ready = 1'b1;
        repeat (4) @(posedge CLK);
        RESET_N <= 1'b1;
    end

    initial begin : compare
        int          cycles;
        int          n_seen;
        logic [31:0] last_pc;
        logic        first_cycle;
        cycles      = 0;
        n_seen      = 0;
        last_pc     = '0;
        first_cycle = 1'b1;
        wait (prog_ready);
        @(posedge CLK);                          // Sample only once the clock is running
        while (cycles < limit) begin
            @(negedge CLK);
            check_value("reset", {31'b0, RESET_N}, {31'b0, IREQ});
            if (DREQ && DRW) begin
                if (n_seen >= exp_addr.size()) begin
                    stop_with_failure($sformatf("Unexpected store to address %h", DADDR));
                end else begin
                    check_value({tags[n_seen], " addr"}, exp_addr[n_seen], DADDR);
                    check_value({tags[n_seen], " data"}, exp_data[n_seen], DOUT);
                    n_seen++;
                end
            end else if (n_seen == 0) begin
                check_value("reset", 32'd0, {30'b0, DREQ, DRW});  // Quiet before first store
            end
            if (RESET_N) begin
                if (first_cycle) begin
                    check_value("reset", 32'd0, IADDR);
                end else if (IADDR < last_pc) begin
                    stop_with_failure($sformatf("Fetch address went back from %h to %h",
                                                last_pc, IADDR));
                end
                first_cycle = 1'b0;
                last_pc     = IADDR;
                cycles++;
            end
        end
        if (n_seen == exp_addr.size()) begin
            $display("Simulation finished: PASS");
            $finish;
        end else begin
            stop_with_failure($sformatf("Stores missing: only %0d of %0d seen in %0d cycles",
                                        n_seen, exp_addr.size(), limit));
        end
    end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+rtl
rtl/core_pkg.sv
rtl/core_fetch.sv
rtl/reg_file.sv
rtl/core_decode.sv
rtl/core_execute.sv
rtl/core_mem_wb.sv
rtl/core_top.sv
test/tb_core.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing -f src.f --top-module tb_core -o tb_core
./obj_dir/tb_core
